/* Makefile */
TOP = raster_tb
BIN = obj_dir/V$(TOP)
LOG = sim.log

.PHONY: compile run clean

compile: $(BIN)

$(BIN): src.f verilog/*.sv verilog/*.svh sim/*.sv
	verilator --binary --timing -Wno-fatal --top-module $(TOP) -f src.f

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* sim/clock_gen.sv */
// testbench clock (4 ns period) and synchronous reset for two cycles

`timescale 1ns/1ps

module clock_gen (
    output logic clk_o,
    output logic reset_o
);
    initial begin
        clk_o   = 1'b0;
        reset_o = 1'b1;
        forever #2 clk_o = ~clk_o;
    end

    initial begin
        repeat (2) @(posedge clk_o);
        reset_o <= 1'b0;
    end

endmodule

/* sim/raster_tb.sv */
// rasterizer testbench with a command table and a reference coverage and box rule
// write, swap and ready checks bounded by a cycle-count timeout

`timescale 1ns/1ps
`include "raster_params.svh"

module raster_tb;
    import raster_cmd_pkg::*;
    import raster_geom_pkg::*;

    localparam int K_CLEAR = 0;
    localparam int K_DRAW  = 1;
    localparam int K_SWAP  = 2;
    localparam int NROWS   = 7;

    typedef struct {
        int               kind;
        logic [5:0][31:0] v;
        color_t           color;
        int               exp_writes;
    } row_t;

    logic      clk, reset;
    logic      cmd_tvalid, cmd_tready, vram_sel, vram_wr, vram_ack, swap;
    cmd_word_u cmd_tdata;
    vaddr_t    vram_addr;
    color_t    vram_data;
    row_t      rows [NROWS];
    vaddr_t    exp_addr [$];
    int        errors = 0;
    int        swaps = 0;
    int        cycles = 0;
    int        limit = 0;

    clock_gen u_clk (.clk_o(clk), .reset_o(reset));

    vram_model u_vram (
        .clk (clk), .reset_i (reset), .sel_i (vram_sel), .wr_i (vram_wr),
        .addr_i (vram_addr), .data_i (vram_data), .ack_o (vram_ack)
    );

    raster_top DUT (
        .clk (clk), .reset_i (reset),
        .cmd_tvalid_i (cmd_tvalid), .cmd_tready_o (cmd_tready), .cmd_tdata_i (cmd_tdata),
        .vram_sel_o (vram_sel), .vram_wr_o (vram_wr), .vram_ack_i (vram_ack),
        .vram_addr_o (vram_addr), .vram_data_o (vram_data), .swap_o (swap)
    );

    always @(posedge clk) begin
        if (swap)
            swaps++;
        cycles++;
        if (limit > 0 && cycles > limit) begin
            $display("timeout: run did not finish within %0d cycles", limit);
            $display("Simulation failed");
            $finish;
        end
    end

    // low half of a coordinate keeps only the subpixel bits
    function automatic fix_t masked(input logic [31:0] raw);
        return fix_t'({raw[31:16], raw[15:0] & `SUBPIXEL_MASK});
    endfunction

    function automatic fix_t edge_val(input fix_t px, py, ax, ay, bx, by);
        fix_t a, b, c, d;
        a = (px - ax) >>> `MUL_PRESHIFT;
        b = (by - ay) >>> `MUL_PRESHIFT;
        c = (py - ay) >>> `MUL_PRESHIFT;
        d = (bx - ax) >>> `MUL_PRESHIFT;
        return fix_t'(a * b) - fix_t'(c * d);
    endfunction

    function automatic int clamp(input int v, input int hi);
        return (v < 0) ? 0 : ((v > hi) ? hi : v);
    endfunction

    function automatic int min_of3(input int a, b, c);
        int m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic int max_of3(input int a, b, c);
        int m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    // fills exp_addr with covered pixels of the clamped box
    // returns the box area
    function automatic int expected_pixels(input logic [5:0][31:0] v);
        fix_t vx [3], vy [3], px, py;
        int   ix [3], iy [3], x_lo, x_hi, y_lo, y_hi;
        exp_addr.delete();
        for (int i = 0; i < 3; i++) begin
            vx[i] = masked(v[2*i]);
            vy[i] = masked(v[2*i+1]);
            ix[i] = int'($signed(v[2*i][31:16]));
            iy[i] = int'($signed(v[2*i+1][31:16]));
        end
        x_lo = clamp(min_of3(ix[0], ix[1], ix[2]), `FB_WIDTH - 1);
        x_hi = clamp(max_of3(ix[0], ix[1], ix[2]), `FB_WIDTH - 1);
        y_lo = clamp(min_of3(iy[0], iy[1], iy[2]), `FB_HEIGHT - 1);
        y_hi = clamp(max_of3(iy[0], iy[1], iy[2]), `FB_HEIGHT - 1);
        if (x_lo > x_hi || y_lo > y_hi)
            return 0;
        for (int y = y_lo; y <= y_hi; y++) begin
            for (int x = x_lo; x <= x_hi; x++) begin
                px = fix_t'(x) <<< `FRAC_BITS;
                py = fix_t'(y) <<< `FRAC_BITS;
                if (edge_val(px, py, vx[1], vy[1], vx[2], vy[2]) >= 0 &&
                    edge_val(px, py, vx[2], vy[2], vx[0], vy[0]) >= 0 &&
                    edge_val(px, py, vx[0], vy[0], vx[1], vy[1]) >= 0)
                    exp_addr.push_back(vaddr_t'(y * `FB_WIDTH + x));
            end
        end
        return (x_hi - x_lo + 1) * (y_hi - y_lo + 1);
    endfunction

    task automatic expect_bit(input string name, input logic actual, input logic expected);
        assert (actual === expected)
        else begin
            errors++;
            $display("Fail t=%0t %s expected %b actual %b", $time, name, expected, actual);
        end
    endtask

    task automatic send_cmd(input opcode_t op, input logic hi, input logic [15:0] value);
        cmd_word_u w;
        w                   = '0;
        w.set_view.opcode   = op;
        w.set_view.hi       = hi;
        w.set_view.value    = value;
        @(posedge clk);
        cmd_tvalid <= 1'b1;
        cmd_tdata  <= w;
        @(posedge clk);
        cmd_tvalid <= 1'b0;
        @(posedge clk);
        expect_bit("cmd_tready_o", cmd_tready, 1'b0);
        while (!cmd_tready)
            @(posedge clk);
    endtask

    task automatic add_row(input int idx, kind, input logic [5:0][31:0] v,
                           input color_t color, input int exp_writes);
        rows[idx] = '{kind, v, color, exp_writes};
    endtask

    initial begin
        void'($urandom(11));
        cmd_tvalid = 1'b0;
        cmd_tdata  = '0;
        // vertices listed y2 x2 y1 x1 y0 x0
        // low halves carry bits below the mask
        add_row(0, K_CLEAR, '0, 16'hF123, `FB_WIDTH * `FB_HEIGHT);
        add_row(1, K_DRAW, {32'h000C_C000, 32'h001B_4567, 32'h0019_0000, 32'h0005_8123,
                            32'h0002_0FFF, 32'h0003_2ABC}, 16'hF0A5, -1);
        // clockwise copy of row 1
        add_row(2, K_DRAW, {32'h0019_0000, 32'h0005_8123, 32'h000C_C000, 32'h001B_4567,
                            32'h0002_0FFF, 32'h0003_2ABC}, 16'hF0A5, 0);
        add_row(3, K_DRAW, {32'h000A_0000, 32'h0028_0000, 32'h002D_0123, 32'h0004_0000,
                            32'hFFFC_C0F0, 32'hFFF9_8ABC}, 16'h8C3E, -1);
        add_row(4, K_DRAW, {32'h0028_0000, 32'h0032_0000, 32'h0032_0000, 32'h0028_0000,
                            32'h0028_0000, 32'h0028_0000}, 16'h1234, 0);
        add_row(5, K_SWAP, '0, 16'h0000, 0);
        add_row(6, K_CLEAR, '0, 16'h0000, `FB_WIDTH * `FB_HEIGHT);

        // worst case about 8 cycles per clear write and 20 per box pixel
        limit = 100;
        for (int r = 0; r < NROWS; r++) begin
            limit += 100;
            if (rows[r].kind == K_CLEAR)
                limit += `FB_WIDTH * `FB_HEIGHT * 8;
            if (rows[r].kind == K_DRAW)
                limit += (expected_pixels(rows[r].v) + 1) * 20;
        end

        @(negedge reset);
        @(posedge clk);
        expect_bit("cmd_tready_o", cmd_tready, 1'b1);
        expect_bit("vram_sel_o", vram_sel, 1'b0);
        expect_bit("vram_wr_o", vram_wr, 1'b0);
        expect_bit("swap_o", swap, 1'b0);

        for (int r = 0; r < NROWS; r++) begin
            u_vram.addr_q.delete();
            u_vram.data_q.delete();
            swaps = 0;
            exp_addr.delete();
            if (rows[r].kind == K_CLEAR) begin
                for (int i = 0; i < `FB_WIDTH * `FB_HEIGHT; i++)
                    exp_addr.push_back(vaddr_t'(i));
                send_cmd(CLEAR, rows[r].color[15], rows[r].color);
            end else if (rows[r].kind == K_DRAW) begin
                void'(expected_pixels(rows[r].v));
                for (int i = 0; i < 6; i++) begin
                    send_cmd(opcode_t'(i), 1'b1, rows[r].v[i][31:16]);
                    send_cmd(opcode_t'(i), 1'b0, rows[r].v[i][15:0]);
                end
                send_cmd(SET_COLOR, rows[r].color[15], rows[r].color);
                send_cmd(DRAW, 1'b0, 16'h0000);
            end else begin
                send_cmd(SWAP, 1'b0, 16'h0000);
            end
            repeat (2) @(posedge clk);

            if (rows[r].kind == K_DRAW && rows[r].exp_writes >= 0) begin
                assert (exp_addr.size() == rows[r].exp_writes)
                else begin
                    errors++;
                    $display("row %0d: reference pixel count disagrees with the table", r);
                end
            end else if (rows[r].kind == K_DRAW) begin
                assert (exp_addr.size() > 0)
                else begin
                    errors++;
                    $display("row %0d: reference triangle covers no pixel", r);
                end
            end
            assert (u_vram.addr_q.size() == exp_addr.size())
            else begin
                errors++;
                $display("Fail t=%0t write_count row %0d expected %0d actual %0d",
                         $time, r, exp_addr.size(), u_vram.addr_q.size());
            end
            for (int i = 0; i < exp_addr.size() && i < u_vram.addr_q.size(); i++) begin
                assert (u_vram.addr_q[i] == exp_addr[i] && u_vram.data_q[i] == rows[r].color)
                else begin
                    errors++;
                    $display("Fail t=%0t vram_addr_o/vram_data_o expected %h/%h actual %h/%h",
                             $time, exp_addr[i], rows[r].color,
                             u_vram.addr_q[i], u_vram.data_q[i]);
                end
            end
            assert (swaps == ((rows[r].kind == K_SWAP) ? 1 : 0))
            else begin
                errors++;
                $display("Fail t=%0t swap_o expected %0d actual %0d pulse cycles", $time,
                         (rows[r].kind == K_SWAP) ? 1 : 0, swaps);
            end
        end

        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

/* sim/vram_model.sv */
// behavioural video memory that acks each write after 0 to 3 extra cycles
// records every acknowledged write in order

`timescale 1ns/1ps

module vram_model (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    sel_i,
    input  logic                    wr_i,
    input  raster_geom_pkg::vaddr_t addr_i,
    input  raster_geom_pkg::color_t data_i,
    output logic                    ack_o = 1'b0
);
    import raster_geom_pkg::*;

    vaddr_t addr_q [$];
    color_t data_q [$];
    logic   busy;
    int     wait_cnt;

    always @(posedge clk) begin
        if (reset_i) begin
            ack_o <= 1'b0;
            busy  = 1'b0;
        end else if (ack_o) begin
            ack_o <= 1'b0;
        end else if (sel_i && wr_i) begin
            if (!busy) begin
                busy     = 1'b1;
                wait_cnt = $urandom % 4;
            end
            if (wait_cnt == 0) begin
                ack_o <= 1'b1;
                busy  = 1'b0;
                addr_q.push_back(addr_i);
                data_q.push_back(data_i);
            end else begin
                wait_cnt--;
            end
        end
    end

endmodule

/* src.f */
+incdir+verilog
verilog/raster_geom_pkg.sv
verilog/raster_cmd_pkg.sv
verilog/triangle_setup.sv
verilog/pixel_scan_counter.sv
verilog/edge_eval.sv
verilog/raster_ctrl_fsm.sv
verilog/raster_top.sv
sim/clock_gen.sv
sim/vram_model.sv
sim/raster_tb.sv

/* verilog/edge_eval.sv */
// three edge functions of one pixel on a single registered multiplier
// done comes 7 cycles after start, point and vertices held meanwhile

`timescale 1ns/1ps
`include "raster_params.svh"

module edge_eval (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    start_i,
    input  raster_geom_pkg::coord_t px_i,
    input  raster_geom_pkg::coord_t py_i,
    input  raster_geom_pkg::fix_t   x0_i,
    input  raster_geom_pkg::fix_t   y0_i,
    input  raster_geom_pkg::fix_t   x1_i,
    input  raster_geom_pkg::fix_t   y1_i,
    input  raster_geom_pkg::fix_t   x2_i,
    input  raster_geom_pkg::fix_t   y2_i,
    output logic                    done_o,
    output logic                    inside_o
);
    import raster_geom_pkg::*;

    fix_t       vx [3];
    fix_t       vy [3];
    fix_t       pt_x, pt_y;
    logic       busy;
    logic [2:0] cnt;
    logic [2:0] issue_idx;
    logic [1:0] edge_idx, va, vb;
    fix_t       diff_a, diff_b;
    fix_t       op_a, op_b, prod_r;
    fix_t       t_r, w0_r, w1_r, w2;

    assign vx   = '{x0_i, x1_i, x2_i};
    assign vy   = '{y0_i, y1_i, y2_i};
    assign pt_x = fix_t'(px_i) <<< `FRAC_BITS;
    assign pt_y = fix_t'(py_i) <<< `FRAC_BITS;

    // product 2e and 2e+1 form edge e, vertices rotate (1,2) (2,0) (0,1)
    assign issue_idx = start_i ? 3'd0 : cnt;
    assign edge_idx  = issue_idx[2:1];
    assign va        = (edge_idx == 2'd2) ? 2'd0 : edge_idx + 2'd1;
    assign vb        = (edge_idx == 2'd0) ? 2'd2 : edge_idx - 2'd1;
    assign diff_a    = issue_idx[0] ? pt_y - vy[va] : pt_x - vx[va];
    assign diff_b    = issue_idx[0] ? vx[vb] - vx[va] : vy[vb] - vy[va];

    always_ff @(posedge clk) begin
        op_a   <= diff_a >>> `MUL_PRESHIFT;
        op_b   <= diff_b >>> `MUL_PRESHIFT;
        prod_r <= op_a * op_b;
        // product k shows up in prod_r when cnt is k+2
        if (busy) begin
            case (cnt)
                3'd2, 3'd4, 3'd6: t_r <= prod_r;
                3'd3:             w0_r <= t_r - prod_r;
                3'd5:             w1_r <= t_r - prod_r;
                default:          ;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy <= 1'b0;
            cnt  <= 3'd0;
        end else if (start_i) begin
            busy <= 1'b1;
            cnt  <= 3'd1;
        end else if (busy) begin
            busy <= (cnt != 3'd7);
            cnt  <= cnt + 3'd1;
        end
    end

    // last edge is formed straight from the final product
    assign w2       = t_r - prod_r;
    assign done_o   = busy && (cnt == 3'd7);
    assign inside_o = !w0_r[31] && !w1_r[31] && !w2[31];

endmodule

/* verilog/pixel_scan_counter.sv */
// row-major pixel counter over a box or the whole frame
// keeps the linear frame buffer address alongside x and y

`timescale 1ns/1ps
`include "raster_params.svh"

module pixel_scan_counter (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    load_i,
    input  logic                    clear_i,
    input  logic                    step_i,
    input  raster_geom_pkg::coord_t min_x_i,
    input  raster_geom_pkg::coord_t min_y_i,
    input  raster_geom_pkg::coord_t max_x_i,
    input  raster_geom_pkg::coord_t max_y_i,
    output raster_geom_pkg::coord_t x_o,
    output raster_geom_pkg::coord_t y_o,
    output raster_geom_pkg::vaddr_t addr_o,
    output logic                    last_o,
    output logic                    empty_o
);
    import raster_geom_pkg::*;

    coord_t ld_min_x, ld_min_y, ld_max_x, ld_max_y;
    coord_t x_r, y_r;
    coord_t min_x_r, max_x_r, max_y_r;
    vaddr_t addr_r;
    logic   empty_r;

    // a clear sweeps the full frame
    assign ld_min_x = clear_i ? coord_t'(0) : min_x_i;
    assign ld_min_y = clear_i ? coord_t'(0) : min_y_i;
    assign ld_max_x = clear_i ? coord_t'(`FB_WIDTH - 1) : max_x_i;
    assign ld_max_y = clear_i ? coord_t'(`FB_HEIGHT - 1) : max_y_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            x_r     <= '0;
            y_r     <= '0;
            addr_r  <= '0;
            empty_r <= 1'b1;
        end else if (load_i) begin
            x_r     <= ld_min_x;
            y_r     <= ld_min_y;
            addr_r  <= vaddr_t'(ld_min_y) * `FB_WIDTH + vaddr_t'(ld_min_x);
            empty_r <= (ld_min_x > ld_max_x) || (ld_min_y > ld_max_y);
        end else if (step_i) begin
            if (x_r < max_x_r) begin
                x_r    <= x_r + 12'sd1;
                addr_r <= addr_r + 32'd1;
            end else begin
                x_r    <= min_x_r;
                y_r    <= y_r + 12'sd1;
                // jump over the columns right and left of the box
                addr_r <= addr_r + `FB_WIDTH - vaddr_t'(max_x_r) + vaddr_t'(min_x_r);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (load_i) begin
            min_x_r <= ld_min_x;
            max_x_r <= ld_max_x;
            max_y_r <= ld_max_y;
        end
    end

    assign x_o     = x_r;
    assign y_o     = y_r;
    assign addr_o  = addr_r;
    assign last_o  = (x_r == max_x_r) && (y_r == max_y_r);
    assign empty_o = empty_r;

endmodule

/* verilog/raster_cmd_pkg.sv */
// command opcodes and the two views of a 32-bit command word

package raster_cmd_pkg;

    typedef enum logic [7:0] {
        SET_X0    = 8'h00,
        SET_Y0    = 8'h01,
        SET_X1    = 8'h02,
        SET_Y1    = 8'h03,
        SET_X2    = 8'h04,
        SET_Y2    = 8'h05,
        SET_COLOR = 8'h06,
        CLEAR     = 8'h07,
        DRAW      = 8'h08,
        SWAP      = 8'h09
    } opcode_t;

    // coordinate writes carry a half select and a 16-bit value
    typedef struct packed {
        opcode_t     opcode;
        logic [6:0]  rsvd;
        logic        hi;
        logic [15:0] value;
    } set_view_t;

    typedef struct packed {
        opcode_t                 opcode;
        logic [7:0]              rsvd;
        raster_geom_pkg::color_t color;
    } color_view_t;

    typedef union packed {
        set_view_t   set_view;
        color_view_t color_view;
    } cmd_word_u;

endpackage

/* verilog/raster_ctrl_fsm.sv */
// command decode and sequencing of set, clear, draw and swap
// owns the video memory write handshake

`timescale 1ns/1ps

module raster_ctrl_fsm (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      cmd_tvalid_i,
    output logic                      cmd_tready_o,
    input  raster_cmd_pkg::cmd_word_u cmd_tdata_i,
    output logic                      vram_sel_o,
    output logic                      vram_wr_o,
    input  logic                      vram_ack_i,
    output raster_geom_pkg::vaddr_t   vram_addr_o,
    output raster_geom_pkg::color_t   vram_data_o,
    output logic                      swap_o,
    output logic                      setup_we_o,
    output raster_geom_pkg::vtx_sel_t setup_sel_o,
    output logic                      setup_hi_o,
    output logic [15:0]               setup_value_o,
    output logic                      scan_load_o,
    output logic                      scan_clear_o,
    output logic                      scan_step_o,
    output logic                      eval_start_o,
    input  raster_geom_pkg::color_t   draw_color_i,
    input  raster_geom_pkg::vaddr_t   scan_addr_i,
    input  logic                      scan_last_i,
    input  logic                      scan_empty_i,
    input  logic                      eval_done_i,
    input  logic                      eval_inside_i
);
    import raster_cmd_pkg::*;
    import raster_geom_pkg::*;

    typedef enum logic [2:0] {
        IDLE, DECODE, CLR_ISSUE, CLR_WAIT, DRAW_START, DRAW_EVAL, DRAW_WAIT, DRAW_NEXT
    } state_t;

    state_t    state;
    cmd_word_u cmd_r;
    opcode_t   op;
    logic      is_set;

    always_ff @(posedge clk) begin
        if (cmd_tvalid_i && cmd_tready_o)
            cmd_r <= cmd_tdata_i;
    end

    assign op           = cmd_r.set_view.opcode;
    assign cmd_tready_o = (state == IDLE);

    // set opcodes map onto the setup register file
    always_comb begin
        is_set      = 1'b1;
        setup_sel_o = SEL_COLOR;
        case (op)
            SET_X0:    setup_sel_o = SEL_X0;
            SET_Y0:    setup_sel_o = SEL_Y0;
            SET_X1:    setup_sel_o = SEL_X1;
            SET_Y1:    setup_sel_o = SEL_Y1;
            SET_X2:    setup_sel_o = SEL_X2;
            SET_Y2:    setup_sel_o = SEL_Y2;
            SET_COLOR: setup_sel_o = SEL_COLOR;
            default:   is_set = 1'b0;
        endcase
    end

    assign setup_we_o    = (state == DECODE) && is_set;
    assign setup_hi_o    = cmd_r.set_view.hi;
    assign setup_value_o = cmd_r.set_view.value;

    assign scan_load_o  = (state == DECODE) && (op == CLEAR || op == DRAW);
    assign scan_clear_o = (op == CLEAR);
    assign scan_step_o  = !scan_last_i &&
                          (((state == CLR_WAIT) && vram_ack_i) || (state == DRAW_NEXT));
    assign eval_start_o = (state == DRAW_START) && !scan_empty_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state      <= IDLE;
            vram_sel_o <= 1'b0;
            vram_wr_o  <= 1'b0;
            swap_o     <= 1'b0;
        end else begin
            swap_o <= 1'b0;
            case (state)
                IDLE: begin
                    if (cmd_tvalid_i)
                        state <= DECODE;
                end
                DECODE: begin
                    case (op)
                        CLEAR: begin
                            vram_data_o <= cmd_r.color_view.color;
                            state       <= CLR_ISSUE;
                        end
                        DRAW: begin
                            vram_data_o <= draw_color_i;
                            state       <= DRAW_START;
                        end
                        SWAP: begin
                            swap_o <= 1'b1;
                            state  <= IDLE;
                        end
                        default:
                            state <= IDLE;
                    endcase
                end
                CLR_ISSUE: begin
                    vram_sel_o  <= 1'b1;
                    vram_wr_o   <= 1'b1;
                    vram_addr_o <= scan_addr_i;
                    state       <= CLR_WAIT;
                end
                CLR_WAIT: begin
                    if (vram_ack_i) begin
                        vram_sel_o <= 1'b0;
                        vram_wr_o  <= 1'b0;
                        state      <= scan_last_i ? IDLE : CLR_ISSUE;
                    end
                end
                DRAW_START: begin
                    state <= scan_empty_i ? IDLE : DRAW_EVAL;
                end
                DRAW_EVAL: begin
                    if (eval_done_i && eval_inside_i) begin
                        vram_sel_o  <= 1'b1;
                        vram_wr_o   <= 1'b1;
                        vram_addr_o <= scan_addr_i;
                        state       <= DRAW_WAIT;
                    end else if (eval_done_i) begin
                        state <= DRAW_NEXT;
                    end
                end
                DRAW_WAIT: begin
                    if (vram_ack_i) begin
                        vram_sel_o <= 1'b0;
                        vram_wr_o  <= 1'b0;
                        state      <= DRAW_NEXT;
                    end
                end
                DRAW_NEXT: begin
                    state <= scan_last_i ? IDLE : DRAW_START;
                end
                default:
                    state <= IDLE;
            endcase
        end
    end

endmodule

/* verilog/raster_geom_pkg.sv */
// geometry types: fixed-point values, pixel coordinates, colours,
// video memory addresses and the setup register selector

package raster_geom_pkg;

    typedef logic signed [31:0] fix_t;
    typedef logic signed [11:0] coord_t;
    typedef logic [31:0]        vaddr_t;

    typedef struct packed {
        logic [3:0] a;
        logic [3:0] r;
        logic [3:0] g;
        logic [3:0] b;
    } color_t;

    // coordinate order matches the vertex register file
    typedef enum logic [2:0] {
        SEL_X0, SEL_Y0, SEL_X1, SEL_Y1, SEL_X2, SEL_Y2, SEL_COLOR
    } vtx_sel_t;

endpackage

/* verilog/raster_params.svh */
// frame size, fixed-point format and multiplier operand scaling
// shared by the setup, scan and edge datapaths

`ifndef RASTER_PARAMS_SVH
`define RASTER_PARAMS_SVH

`define FB_WIDTH      32
`define FB_HEIGHT     32

// 16.16 coordinates, low half keeps only the top subpixel bits
`define FRAC_BITS     16
`define SUBPIXEL_MASK 16'hF000

// each difference is scaled down before the 32-bit multiply
`define MUL_PRESHIFT  8

`endif

/* verilog/raster_top.sv */
// triangle rasterizer top level
// command control, vertex setup, pixel scan and edge evaluation

`timescale 1ns/1ps

module raster_top (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      cmd_tvalid_i,
    output logic                      cmd_tready_o,
    input  raster_cmd_pkg::cmd_word_u cmd_tdata_i,
    output logic                      vram_sel_o,
    output logic                      vram_wr_o,
    input  logic                      vram_ack_i,
    output raster_geom_pkg::vaddr_t   vram_addr_o,
    output raster_geom_pkg::color_t   vram_data_o,
    output logic                      swap_o
);
    import raster_geom_pkg::*;

    logic        setup_we, setup_hi;
    vtx_sel_t    setup_sel;
    logic [15:0] setup_value;
    fix_t        x0, y0, x1, y1, x2, y2;
    coord_t      min_x, min_y, max_x, max_y;
    color_t      draw_color;
    logic        scan_load, scan_clear, scan_step, scan_last, scan_empty;
    coord_t      scan_x, scan_y;
    vaddr_t      scan_addr;
    logic        eval_start, eval_done, eval_inside;

    raster_ctrl_fsm u_ctrl (
        .clk           (clk),
        .reset_i       (reset_i),
        .cmd_tvalid_i  (cmd_tvalid_i),
        .cmd_tready_o  (cmd_tready_o),
        .cmd_tdata_i   (cmd_tdata_i),
        .vram_sel_o    (vram_sel_o),
        .vram_wr_o     (vram_wr_o),
        .vram_ack_i    (vram_ack_i),
        .vram_addr_o   (vram_addr_o),
        .vram_data_o   (vram_data_o),
        .swap_o        (swap_o),
        .setup_we_o    (setup_we),
        .setup_sel_o   (setup_sel),
        .setup_hi_o    (setup_hi),
        .setup_value_o (setup_value),
        .scan_load_o   (scan_load),
        .scan_clear_o  (scan_clear),
        .scan_step_o   (scan_step),
        .eval_start_o  (eval_start),
        .draw_color_i  (draw_color),
        .scan_addr_i   (scan_addr),
        .scan_last_i   (scan_last),
        .scan_empty_i  (scan_empty),
        .eval_done_i   (eval_done),
        .eval_inside_i (eval_inside)
    );

    triangle_setup u_setup (
        .clk     (clk),
        .reset_i (reset_i),
        .we_i    (setup_we),
        .sel_i   (setup_sel),
        .hi_i    (setup_hi),
        .value_i (setup_value),
        .x0_o    (x0),
        .y0_o    (y0),
        .x1_o    (x1),
        .y1_o    (y1),
        .x2_o    (x2),
        .y2_o    (y2),
        .min_x_o (min_x),
        .min_y_o (min_y),
        .max_x_o (max_x),
        .max_y_o (max_y),
        .color_o (draw_color)
    );

    pixel_scan_counter u_scan (
        .clk     (clk),
        .reset_i (reset_i),
        .load_i  (scan_load),
        .clear_i (scan_clear),
        .step_i  (scan_step),
        .min_x_i (min_x),
        .min_y_i (min_y),
        .max_x_i (max_x),
        .max_y_i (max_y),
        .x_o     (scan_x),
        .y_o     (scan_y),
        .addr_o  (scan_addr),
        .last_o  (scan_last),
        .empty_o (scan_empty)
    );

    edge_eval u_edge (
        .clk      (clk),
        .reset_i  (reset_i),
        .start_i  (eval_start),
        .px_i     (scan_x),
        .py_i     (scan_y),
        .x0_i     (x0),
        .y0_i     (y0),
        .x1_i     (x1),
        .y1_i     (y1),
        .x2_i     (x2),
        .y2_i     (y2),
        .done_o   (eval_done),
        .inside_o (eval_inside)
    );

endmodule

/* verilog/triangle_setup.sv */
// vertex and flat colour registers
// clamped bounding box of the current triangle

`timescale 1ns/1ps
`include "raster_params.svh"

module triangle_setup (
    input  logic                      clk,
    input  logic                      reset_i,
    input  logic                      we_i,
    input  raster_geom_pkg::vtx_sel_t sel_i,
    input  logic                      hi_i,
    input  logic [15:0]               value_i,
    output raster_geom_pkg::fix_t     x0_o,
    output raster_geom_pkg::fix_t     y0_o,
    output raster_geom_pkg::fix_t     x1_o,
    output raster_geom_pkg::fix_t     y1_o,
    output raster_geom_pkg::fix_t     x2_o,
    output raster_geom_pkg::fix_t     y2_o,
    output raster_geom_pkg::coord_t   min_x_o,
    output raster_geom_pkg::coord_t   min_y_o,
    output raster_geom_pkg::coord_t   max_x_o,
    output raster_geom_pkg::coord_t   max_y_o,
    output raster_geom_pkg::color_t   color_o
);
    import raster_geom_pkg::*;

    fix_t               vtx [6];
    color_t             color_r;
    logic signed [15:0] ix [3];
    logic signed [15:0] iy [3];

    function automatic logic signed [15:0] min3(input logic signed [15:0] a, b, c);
        logic signed [15:0] m;
        m = (a < b) ? a : b;
        return (m < c) ? m : c;
    endfunction

    function automatic logic signed [15:0] max3(input logic signed [15:0] a, b, c);
        logic signed [15:0] m;
        m = (a > b) ? a : b;
        return (m > c) ? m : c;
    endfunction

    function automatic coord_t clamp(input logic signed [15:0] v, lo, hi);
        if (v < lo)
            return coord_t'(lo);
        if (v > hi)
            return coord_t'(hi);
        return coord_t'(v);
    endfunction

    always_ff @(posedge clk) begin
        if (reset_i) begin
            for (int i = 0; i < 6; i++) begin
                vtx[i] <= '0;
            end
            color_r <= '0;
        end else if (we_i) begin
            if (sel_i == SEL_COLOR) begin
                color_r <= color_t'(value_i);
            end else if (hi_i) begin
                vtx[sel_i][31:16] <= value_i;
            end else begin
                vtx[sel_i][15:0] <= value_i & `SUBPIXEL_MASK;
            end
        end
    end

    // integer parts of the vertices
    always_comb begin
        for (int i = 0; i < 3; i++) begin
            ix[i] = 16'(vtx[2*i] >>> `FRAC_BITS);
            iy[i] = 16'(vtx[2*i+1] >>> `FRAC_BITS);
        end
    end

    // limits sit one past the frame so an off-screen box stays empty
    assign min_x_o = clamp(min3(ix[0], ix[1], ix[2]), 16'sd0, 16'(`FB_WIDTH));
    assign min_y_o = clamp(min3(iy[0], iy[1], iy[2]), 16'sd0, 16'(`FB_HEIGHT));
    assign max_x_o = clamp(max3(ix[0], ix[1], ix[2]), -16'sd1, 16'(`FB_WIDTH - 1));
    assign max_y_o = clamp(max3(iy[0], iy[1], iy[2]), -16'sd1, 16'(`FB_HEIGHT - 1));

    assign x0_o    = vtx[0];
    assign y0_o    = vtx[1];
    assign x1_o    = vtx[2];
    assign y1_o    = vtx[3];
    assign x2_o    = vtx[4];
    assign y2_o    = vtx[5];
    assign color_o = color_r;

endmodule
